//--- compile.f
+incdir+hw
hw/soc_io_pkg.sv
hw/bus_watchdog.sv
hw/io_bridge.sv
hw/io_decode.sv
hw/scratch_ram.sv
hw/lfsr_rand.sv
hw/irq_timer.sv
hw/soc_io_top.sv
tests/tb_soc_io.sv

//--- hw/bus_watchdog.sv
`include "soc_io_cfg.svh"

module bus_watchdog (
	input  logic node_clk,
	input  logic rst,
	input  logic busy_i,
	output logic timeout_o
);

	localparam int CNT_W = $clog2(`BUS_TIMEOUT + 1);
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`BUS_TIMEOUT);

	logic [CNT_W-1:0] cnt;

	// counts busy cycles, holds at the limit
	always_ff @(posedge node_clk) begin
		if (rst || !busy_i)
			cnt <= '0;
		else if (cnt != CNT_MAX)
			cnt <= cnt + 1'b1;
	end

	// only meaningful while the bridge waits
	assign timeout_o = busy_i && (cnt == CNT_MAX);

endmodule

//--- hw/io_bridge.sv
module io_bridge import soc_io_pkg::*; (
	input  logic      node_clk,
	input  logic      rst,
	input  wb_req_t   wb_req_i,
	output wb_resp_t  wb_resp_o,
	output wb_req_t   slv_req_o,
	input  slv_resp_t slv_resp_i,
	output logic      busy_o,
	input  logic      timeout_i
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ISSUE,   // one-cycle strobe to the slaves
		ST_WAIT,
		ST_RESPOND, // ack or err to the master
		ST_RECOVER  // master drops stb here
	} state_t;

	state_t      state;
	wb_req_t     req_q;
	logic        resp_ack;
	logic        resp_err;
	logic [31:0] resp_dat;

	// --------------------
	// control
	// --------------------
	always_ff @(posedge node_clk) begin
		if (rst) begin
			state <= ST_IDLE;
			resp_ack <= 1'b0;
			resp_err <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (wb_req_i.cyc && wb_req_i.stb)
						state <= ST_ISSUE;
				end
				ST_ISSUE: state <= ST_WAIT;
				ST_WAIT: begin
					if (slv_resp_i.ack) begin // a late timeout loses to a real ack
						resp_ack <= 1'b1;
						state <= ST_RESPOND;
					end else if (timeout_i) begin
						resp_err <= 1'b1;
						state <= ST_RESPOND;
					end
				end
				ST_RESPOND: begin
					resp_ack <= 1'b0;
					resp_err <= 1'b0;
					state <= ST_RECOVER;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// --------------------
	// payload
	// --------------------
	always_ff @(posedge node_clk) begin
		if (state == ST_IDLE)
			req_q <= wb_req_i; // last one taken is the captured request
		if (state == ST_WAIT)
			resp_dat <= slv_resp_i.ack ? slv_resp_i.dat : 32'h0;
	end

	assign busy_o = (state == ST_ISSUE) || (state == ST_WAIT);

	always_comb begin
		slv_req_o = req_q;
		slv_req_o.cyc = busy_o;
		slv_req_o.stb = (state == ST_ISSUE);
	end

	assign wb_resp_o = '{ack: resp_ack, err: resp_err, dat: resp_dat};

endmodule

//--- hw/io_decode.sv
`include "soc_io_cfg.svh"

module io_decode import soc_io_pkg::*; (
	input  logic       node_clk,
	input  logic       rst,
	input  wb_req_t    slv_req_i,
	output logic       scr_cs_o,
	output logic       rand_cs_o,
	output logic       tmr_cs_o,
	input  slv_resp_t  scr_resp_i,
	input  slv_resp_t  rand_resp_i,
	input  slv_resp_t  tmr_resp_i,
	output slv_resp_t  slv_resp_o,
	output logic [7:0] led_o
);

	logic        led_cs;
	logic        led_hit;
	logic        led_ack;
	logic [7:0]  led_q;
	logic [31:0] led_dat;

	// --------------------
	// chip selects
	// --------------------
	assign scr_cs_o = (slv_req_i.adr[31:20] == `SCR_BASE_HI);
	assign rand_cs_o = (slv_req_i.adr[31:8] == `RAND_PAGE);
	assign tmr_cs_o = (slv_req_i.adr[31:8] == `TMR_PAGE);
	assign led_cs = (slv_req_i.adr[31:8] == `LED_PAGE);

	assign led_hit = led_cs && slv_req_i.stb;

	// --------------------
	// led register
	// --------------------
	always_ff @(posedge node_clk) begin
		if (rst) begin
			led_q <= 8'h00;
			led_ack <= 1'b0;
		end else begin
			led_ack <= led_hit;
			if (led_hit && slv_req_i.we && slv_req_i.sel[0])
				led_q <= slv_req_i.dat[7:0];
		end
	end

	// read data, zero when not reading so the or below stays clean
	always_ff @(posedge node_clk)
		led_dat <= (led_hit && !slv_req_i.we) ? {24'h0, led_q} : 32'h0;

	assign led_o = led_q;

	// --------------------
	// reply merge
	// --------------------
	always_comb begin
		slv_resp_o.ack = scr_resp_i.ack | rand_resp_i.ack | tmr_resp_i.ack | led_ack;
		slv_resp_o.dat = scr_resp_i.dat | rand_resp_i.dat | tmr_resp_i.dat | led_dat;
	end

endmodule

//--- hw/irq_timer.sv
`include "soc_io_cfg.svh"

module irq_timer import soc_io_pkg::*; (
	input  logic      node_clk,
	input  logic      rst,
	input  wb_req_t   slv_req_i,
	input  logic      cs_i,
	output slv_resp_t resp_o,
	output logic      irq_o
);

	logic        hit;
	logic        ack_q;
	logic        irq_q;
	logic [31:0] cnt_q;    // runs 1..period
	logic [31:0] period_q;
	logic [31:0] dat_q;

	assign hit = cs_i && slv_req_i.stb;

	always_ff @(posedge node_clk) begin
		if (rst) begin
			cnt_q <= 32'd1;
			period_q <= `TMR_PERIOD_DEF;
			irq_q <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			ack_q <= hit;

			// --------------------
			// count and wrap
			// --------------------
			if (hit && slv_req_i.we) begin
				period_q <= slv_req_i.dat;
				cnt_q <= 32'd1; // new period starts fresh
			end else if (cnt_q >= period_q)
				cnt_q <= 32'd1;
			else
				cnt_q <= cnt_q + 32'd1;

			// pulse window
			if (cnt_q == `TMR_PULSE_ON)
				irq_q <= 1'b1;
			else if (cnt_q == `TMR_PULSE_OFF)
				irq_q <= 1'b0;
		end
	end

	always_ff @(posedge node_clk)
		dat_q <= (hit && !slv_req_i.we) ? period_q : 32'h0;

	assign resp_o = '{ack: ack_q, dat: dat_q};
	assign irq_o = irq_q;

endmodule

//--- hw/lfsr_rand.sv
`include "soc_io_cfg.svh"

module lfsr_rand import soc_io_pkg::*; (
	input  logic      node_clk,
	input  logic      rst,
	input  wb_req_t   slv_req_i,
	input  logic      cs_i,
	output slv_resp_t resp_o
);

	logic        hit;
	logic        ack_q;
	logic [31:0] lfsr_q;
	logic [31:0] dat_q;

	// galois form, shift right and fold the dropped bit back in
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? `RAND_TAPS : 32'h0);
	endfunction

	assign hit = cs_i && slv_req_i.stb;

	always_ff @(posedge node_clk) begin
		if (rst) begin
			lfsr_q <= `RAND_SEED_DEF;
			ack_q <= 1'b0;
		end else begin
			ack_q <= hit;
			if (hit && slv_req_i.we)
				lfsr_q <= (slv_req_i.dat == 32'h0) ? 32'h1 : slv_req_i.dat; // zero would lock up
			else if (hit)
				lfsr_q <= lfsr_step(lfsr_q); // advance after each read
		end
	end

	always_ff @(posedge node_clk)
		dat_q <= (hit && !slv_req_i.we) ? lfsr_q : 32'h0;

	assign resp_o = '{ack: ack_q, dat: dat_q};

endmodule

//--- hw/scratch_ram.sv
`include "soc_io_cfg.svh"

module scratch_ram import soc_io_pkg::*; (
	input  logic      node_clk,
	input  wb_req_t   slv_req_i,
	input  logic      cs_i,
	output slv_resp_t resp_o
);

	localparam int DEPTH = 1 << `SCR_AW;

	logic [31:0]         mem [DEPTH];
	logic [`SCR_AW-1:0]  word_adr;
	logic                hit;
	logic                ack_q;
	logic                rd_q;
	logic [31:0]         rd_word;

	assign word_adr = slv_req_i.adr[`SCR_AW+1:2];
	assign hit = cs_i && slv_req_i.stb;

	always_ff @(posedge node_clk) begin
		if (hit && slv_req_i.we) begin
			for (int i = 0; i < 4; i++) begin
				if (slv_req_i.sel[i])
					mem[word_adr][8*i +: 8] <= slv_req_i.dat[8*i +: 8];
			end
		end
		rd_word <= mem[word_adr]; // registered read port
	end

	// reply one cycle after the hit
	always_ff @(posedge node_clk) begin
		ack_q <= hit;
		rd_q <= hit && !slv_req_i.we;
	end

	assign resp_o.ack = ack_q;
	assign resp_o.dat = rd_q ? rd_word : 32'h0;

endmodule

//--- hw/soc_io_cfg.svh
`ifndef SOC_IO_CFG_SVH
`define SOC_IO_CFG_SVH

// --------------------
// address map
// --------------------

// scratch memory sits in the 1MB region at 0x0010_0000
`define SCR_BASE_HI 12'h001
`define SCR_AW 12 // word address bits, adr[13:2]

// 256-byte register pages, matched on adr[31:8]
`define LED_PAGE 24'hFD0FFF
`define RAND_PAGE 24'hFD0FFD
`define TMR_PAGE 24'hFD0FFC

// --------------------
// random generator
// --------------------

`define RAND_TAPS 32'h80200003 // galois feedback mask
`define RAND_SEED_DEF 32'h1

// --------------------
// timer and watchdog
// --------------------

`define TMR_PERIOD_DEF 32'd100000
`define TMR_PULSE_ON 32'd150 // count where irq goes high
`define TMR_PULSE_OFF 32'd200
`define BUS_TIMEOUT 32 // busy cycles before bus error

`endif

//--- hw/soc_io_pkg.sv
package soc_io_pkg;

	// --------------------
	// wishbone classic request
	// --------------------
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  sel; // byte lanes
		logic [31:0] adr;
		logic [31:0] dat; // write data
	} wb_req_t;

	// response back to the outside master
	typedef struct packed {
		logic        ack;
		logic        err; // no slave answered in time
		logic [31:0] dat;
	} wb_resp_t;

	// --------------------
	// per-slave reply
	// --------------------

	// dat is zero whenever ack is low so replies can be or'ed
	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} slv_resp_t;

endpackage

//--- hw/soc_io_top.sv
module soc_io_top import soc_io_pkg::*; (
	input  logic       node_clk,
	input  logic       rst,
	input  wb_req_t    wb_req_i,
	output wb_resp_t   wb_resp_o,
	output logic [7:0] led_o,
	output logic       tmr_irq_o
);

	wb_req_t   slv_req;    // bridge to all slaves
	slv_resp_t slv_resp;   // merged reply to bridge
	slv_resp_t scr_resp;
	slv_resp_t rand_resp;
	slv_resp_t tmr_resp;
	logic      busy;
	logic      timeout;
	logic      scr_cs;
	logic      rand_cs;
	logic      tmr_cs;

	io_bridge u_bridge (
		.node_clk   (node_clk),
		.rst        (rst),
		.wb_req_i   (wb_req_i),
		.wb_resp_o  (wb_resp_o),
		.slv_req_o  (slv_req),
		.slv_resp_i (slv_resp),
		.busy_o     (busy),
		.timeout_i  (timeout)
	);

	bus_watchdog u_watchdog (.node_clk(node_clk), .rst(rst), .busy_i(busy), .timeout_o(timeout));

	io_decode u_decode (
		.node_clk    (node_clk),
		.rst         (rst),
		.slv_req_i   (slv_req),
		.scr_cs_o    (scr_cs),
		.rand_cs_o   (rand_cs),
		.tmr_cs_o    (tmr_cs),
		.scr_resp_i  (scr_resp),
		.rand_resp_i (rand_resp),
		.tmr_resp_i  (tmr_resp),
		.slv_resp_o  (slv_resp),
		.led_o       (led_o)
	);

	scratch_ram u_scr (.node_clk(node_clk), .slv_req_i(slv_req), .cs_i(scr_cs), .resp_o(scr_resp));

	lfsr_rand u_rand (
		.node_clk(node_clk), .rst(rst), .slv_req_i(slv_req), .cs_i(rand_cs), .resp_o(rand_resp)
	);

	irq_timer u_tmr (
		.node_clk  (node_clk),
		.rst       (rst),
		.slv_req_i (slv_req),
		.cs_i      (tmr_cs),
		.resp_o    (tmr_resp),
		.irq_o     (tmr_irq_o)
	);

endmodule

//--- tests/tb_soc_io.sv
`include "soc_io_cfg.svh"

module tb_soc_io import soc_io_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] LED_ADR = {`LED_PAGE, 8'h00};
	localparam logic [31:0] RAND_ADR = {`RAND_PAGE, 8'h04}; // any offset in the page
	localparam logic [31:0] TMR_ADR = {`TMR_PAGE, 8'h00};
	localparam logic [31:0] NOWHERE_ADR = 32'h8000_0000;   // no slave decodes this
	localparam int BUS_WAIT_MAX = 100;
	localparam int IRQ_WAIT_MAX = 1000;

	logic        node_clk;
	logic        rst;
	wb_req_t     wb_req;
	wb_resp_t    wb_resp;
	logic [7:0]  led;
	logic        tmr_irq;
	logic [31:0] scr_model [int]; // expected words by index
	logic [11:0] scr_idx [16];

	soc_io_top UUT (
		.node_clk  (node_clk),
		.rst       (rst),
		.wb_req_i  (wb_req),
		.wb_resp_o (wb_resp),
		.led_o     (led),
		.tmr_irq_o (tmr_irq)
	);

	initial begin
		node_clk = 1'b0;
		forever #2 node_clk = ~node_clk;
	end

	// --------------------
	// checking
	// --------------------
	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("mismatch in %s: expected %h, actual %h", name, exp, act);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else report_mismatch(name, exp, act);
	endtask

	// --------------------
	// reference models
	// --------------------
	function automatic logic [31:0] rand_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ `RAND_TAPS; // a one fell out
		return n;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] dat,
			input logic [3:0] sel);
		logic [31:0] r;
		r = old;
		for (int i = 0; i < 4; i++)
			if (sel[i])
				r[8*i +: 8] = dat[8*i +: 8];
		return r;
	endfunction

	function automatic logic [31:0] scr_adr(input logic [11:0] idx);
		return {`SCR_BASE_HI, 6'h0, idx, 2'b00};
	endfunction

	// --------------------
	// bus access
	// --------------------

	// one classic cycle entered and left on a falling edge
	task automatic bus_cycle(input string name, input logic we, input logic [3:0] sel,
			input logic [31:0] adr, input logic [31:0] wdat, input logic want_err,
			output logic [31:0] rdat);
		int n;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: wdat};
		n = 0;
		do begin
			@(negedge node_clk);
			n++;
			if (n > BUS_WAIT_MAX)
				report_failure($sformatf("%s got neither ack nor err in time", name));
		end while (!wb_resp.ack && !wb_resp.err);
		check_eq({name, " ack"}, {31'h0, !want_err}, {31'h0, wb_resp.ack});
		check_eq({name, " err"}, {31'h0, want_err}, {31'h0, wb_resp.err});
		if (want_err)
			check_eq({name, " err data"}, 32'h0, wb_resp.dat);
		else
			check_eq({name, " latency"}, 32'd3, n); // capture then slave then response
		rdat = wb_resp.dat;
		wb_req = '0;
		@(negedge node_clk);
		check_eq({name, " response width"}, 32'h0, {30'h0, wb_resp.ack, wb_resp.err});
		@(negedge node_clk); // bridge recovery
	endtask

	task automatic bus_write(input string name, input logic [31:0] adr, input logic [3:0] sel,
			input logic [31:0] dat);
		logic [31:0] discard;
		bus_cycle(name, 1'b1, sel, adr, dat, 1'b0, discard);
	endtask

	task automatic bus_read(input string name, input logic [31:0] adr, output logic [31:0] dat);
		bus_cycle(name, 1'b0, 4'hF, adr, 32'h0, 1'b0, dat);
	endtask

	// falling edges until the irq line reaches the level
	task automatic wait_irq(input logic level, output int cycles);
		cycles = 0;
		while (tmr_irq !== level) begin
			@(negedge node_clk);
			cycles++;
			if (cycles > IRQ_WAIT_MAX)
				report_failure($sformatf("tmr_irq_o never went to %0b", level));
		end
	endtask

	// --------------------
	// stimulus
	// --------------------
	initial begin
		logic [31:0] rd;
		logic [31:0] wd;
		logic [31:0] exp;
		logic [11:0] idx;
		logic [3:0]  sel;
		logic [7:0]  led_exp;
		int          k;
		int          hi_cycles;
		int          gap_cycles;

		void'($urandom(94));
		rst = 1'b1;
		wb_req = '0;
		repeat (4) @(posedge node_clk);
		@(negedge node_clk);
		rst = 1'b0;
		@(negedge node_clk);

		check_eq("reset ack", 32'h0, {31'h0, wb_resp.ack});
		check_eq("reset err", 32'h0, {31'h0, wb_resp.err});
		check_eq("reset led", 32'h0, {24'h0, led});
		check_eq("reset irq", 32'h0, {31'h0, tmr_irq});
		bus_read("reset rand state", RAND_ADR, rd);
		check_eq("reset rand state", `RAND_SEED_DEF, rd);
		bus_read("reset timer period", TMR_ADR, rd);
		check_eq("reset timer period", `TMR_PERIOD_DEF, rd);

		// full fill first so every scratch byte is known
		for (k = 0; k < 16; k++) begin
			scr_idx[k] = 12'($urandom());
			wd = $urandom();
			bus_write("scratch fill", scr_adr(scr_idx[k]), 4'hF, wd);
			scr_model[scr_idx[k]] = wd;
		end
		for (k = 0; k < 40; k++) begin
			idx = scr_idx[$urandom() % 16];
			sel = 4'($urandom());
			wd = $urandom();
			bus_write("scratch partial write", scr_adr(idx), sel, wd);
			scr_model[idx] = merge_bytes(scr_model[idx], wd, sel);
			if (k % 4 == 3) begin
				bus_read("scratch read", scr_adr(idx), rd);
				check_eq("scratch interleaved read", scr_model[idx], rd);
			end
		end
		for (k = 0; k < 16; k++) begin
			bus_read("scratch read", scr_adr(scr_idx[k]), rd);
			check_eq("scratch final read", scr_model[scr_idx[k]], rd);
		end

		wd = $urandom();
		led_exp = wd[7:0];
		bus_write("led write", LED_ADR, 4'h1, wd);
		check_eq("led output", {24'h0, led_exp}, {24'h0, led});
		bus_read("led read", LED_ADR, rd);
		check_eq("led read", {24'h0, led_exp}, rd);
		bus_write("led write lane 0 off", LED_ADR, 4'hE, ~wd);
		check_eq("led output kept", {24'h0, led_exp}, {24'h0, led});

		wd = $urandom() | 32'h1;
		bus_write("rand seed", RAND_ADR, 4'hF, wd);
		exp = wd;
		for (k = 0; k < 10; k++) begin
			bus_read("rand read", RAND_ADR, rd);
			check_eq("rand sequence", exp, rd);
			exp = rand_next(exp);
		end
		bus_write("rand zero seed", RAND_ADR, 4'hF, 32'h0);
		bus_read("rand read", RAND_ADR, rd);
		check_eq("rand after zero seed", 32'h1, rd);
		bus_read("rand read", RAND_ADR, rd);
		check_eq("rand step after zero seed", rand_next(32'h1), rd);

		bus_cycle("unmapped read", 1'b0, 4'hF, NOWHERE_ADR, 32'h0, 1'b1, rd);
		bus_cycle("unmapped write", 1'b1, 4'hF, NOWHERE_ADR, $urandom(), 1'b1, rd);
		bus_read("read after bus error", LED_ADR, rd);
		check_eq("read after bus error", {24'h0, led_exp}, rd);

		bus_write("timer period", TMR_ADR, 4'hF, 32'd300);
		bus_read("timer period read", TMR_ADR, rd);
		check_eq("timer period read", 32'd300, rd);
		wait_irq(1'b0, k); // may still be inside an old pulse
		wait_irq(1'b1, k);
		wait_irq(1'b0, hi_cycles);
		check_eq("timer pulse width", 32'd50, hi_cycles);
		wait_irq(1'b1, gap_cycles);
		check_eq("timer pulse period", 32'd300, hi_cycles + gap_cycles);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule
